// ==== cnn_settings.svh ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CNN address core sizes and plane offsets
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef CNN_SETTINGS_SVH
`define CNN_SETTINGS_SVH

// input image is square, one word per pixel
`define CNN_IMG_SIDE 28

// conv kernel side, one kernel per filter
`define CNN_K_SIDE 5

// valid conv output side (28 - 5 + 1)
`define CNN_CONV_SIDE 24

// after 2x2 max pooling
`define CNN_POOL_SIDE 12

// base of conv channel 1 in the conv output memory
`define CNN_CONV_PLANE 576

// base of pool channel 1 in the pooled memory
`define CNN_POOL_PLANE 144

// base of the weights for fc output 1
`define CNN_FC_PLANE 288

`endif

// ==== cnn_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CNN address core types
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "cnn_settings.svh"

package cnn_pkg;

    // image memory, 784 words
    typedef logic [$clog2(`CNN_IMG_SIDE * `CNN_IMG_SIDE)-1:0] img_addr_t;

    // two 25-tap kernels back to back
    typedef logic [$clog2(2 * `CNN_K_SIDE * `CNN_K_SIDE)-1:0] k_addr_t;

    // two conv output planes
    typedef logic [$clog2(2 * `CNN_CONV_PLANE)-1:0] conv_addr_t;

    // two pooled planes
    typedef logic [$clog2(2 * `CNN_POOL_PLANE)-1:0] pool_addr_t;

    // fc weights, one block of 288 per output
    typedef logic [$clog2(2 * `CNN_FC_PLANE)-1:0] fc_addr_t;

    typedef enum logic [2:0] {
        phase_idle,
        phase_load,
        phase_conv,
        phase_pool,
        phase_fc,
        phase_finish
    } phase_t;

endpackage

// ==== linear_addr_gen.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two-lane stepping address counter
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// lane 0 counts 0..LAST, lane 1 follows at a fixed offset
module linear_addr_gen #(
    parameter int WIDTH       = 10,
    parameter int LANE_OFFSET = 288,
    parameter int LAST        = 287
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             run,
    input  logic             step,
    output logic [WIDTH-1:0] addr0,
    output logic [WIDTH-1:0] addr1,
    output logic             last
);

    localparam logic [WIDTH-1:0] LAST_W   = WIDTH'(LAST);
    localparam logic [WIDTH-1:0] OFFSET_W = WIDTH'(LANE_OFFSET);
    localparam logic [WIDTH-1:0] ONE_W    = WIDTH'(1);

    logic at_last;

    assign at_last = (addr0 == LAST_W);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            addr0 <= '0;
        end else if (!run) begin
            // idle counter waits at the first address
            addr0 <= '0;
        end else if (step) begin
            if (at_last) begin
                addr0 <= '0;
            end else begin
                addr0 <= addr0 + ONE_W;
            end
        end
    end

    // second lane is the other channel or filter
    assign addr1 = addr0 + OFFSET_W;

    assign last = at_last;

endmodule

// ==== pool_window_addr_gen.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 2x2 pooling window address walker
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "cnn_settings.svh"

module pool_window_addr_gen (
    input  logic                clk,
    input  logic                reset,
    input  logic                run,
    output cnn_pkg::conv_addr_t a0,
    output cnn_pkg::conv_addr_t a1,
    output cnn_pkg::conv_addr_t a2,
    output cnn_pkg::conv_addr_t a3,
    output cnn_pkg::conv_addr_t b0,
    output cnn_pkg::conv_addr_t b1,
    output cnn_pkg::conv_addr_t b2,
    output cnn_pkg::conv_addr_t b3,
    output logic                last
);

    localparam logic [3:0] WIN_LAST = 4'(`CNN_POOL_SIDE - 1);

    // step sizes inside the conv plane
    localparam cnn_pkg::conv_addr_t COL_STEP  = cnn_pkg::conv_addr_t'(2);
    localparam cnn_pkg::conv_addr_t ROW_SKIP  = cnn_pkg::conv_addr_t'(`CNN_CONV_SIDE + 2);
    localparam cnn_pkg::conv_addr_t RIGHT     = cnn_pkg::conv_addr_t'(1);
    localparam cnn_pkg::conv_addr_t BELOW     = cnn_pkg::conv_addr_t'(`CNN_CONV_SIDE);
    localparam cnn_pkg::conv_addr_t BELOW_R   = cnn_pkg::conv_addr_t'(`CNN_CONV_SIDE + 1);
    localparam cnn_pkg::conv_addr_t PLANE_OFS = cnn_pkg::conv_addr_t'(`CNN_CONV_PLANE);

    cnn_pkg::conv_addr_t base;
    logic [3:0]          col;
    logic [3:0]          row;
    logic                row_end;

    assign row_end = (col == WIN_LAST);
    assign last    = row_end && (row == WIN_LAST);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            base <= '0;
            col  <= '0;
            row  <= '0;
        end else if (!run || last) begin
            // back to the top-left window
            base <= '0;
            col  <= '0;
            row  <= '0;
        end else if (row_end) begin
            // jump over the odd conv row
            base <= base + ROW_SKIP;
            col  <= '0;
            row  <= row + 4'd1;
        end else begin
            base <= base + COL_STEP;
            col  <= col + 4'd1;
        end
    end

    // channel 0 window
    assign a0 = base;
    assign a1 = base + RIGHT;
    assign a2 = base + BELOW;
    assign a3 = base + BELOW_R;

    // same window in channel 1
    assign b0 = a0 + PLANE_OFS;
    assign b1 = a1 + PLANE_OFS;
    assign b2 = a2 + PLANE_OFS;
    assign b3 = a3 + PLANE_OFS;

endmodule

// ==== img_load_ctrl.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Image load pixel handshake
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "cnn_settings.svh"

module img_load_ctrl (
    input  logic               clk,
    input  logic               reset,
    input  logic               load_en,
    input  logic               pix_req,
    output logic               pix_ack,
    output logic               img_wr_en,
    output logic               load_done,
    output cnn_pkg::img_addr_t img_wr_addr
);

    localparam cnn_pkg::img_addr_t LAST_ADDR =
        cnn_pkg::img_addr_t'(`CNN_IMG_SIDE * `CNN_IMG_SIDE - 1);

    // set once the write of the last pixel is issued
    logic full;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pix_ack     <= 1'b0;
            img_wr_en   <= 1'b0;
            load_done   <= 1'b0;
            full        <= 1'b0;
            img_wr_addr <= '0;
        end else if (!load_en) begin
            // outside the load phase, rewind for the next run
            pix_ack     <= 1'b0;
            img_wr_en   <= 1'b0;
            load_done   <= 1'b0;
            full        <= 1'b0;
            img_wr_addr <= '0;
        end else begin
            img_wr_en <= 1'b0;
            if (!pix_ack && pix_req && !full) begin
                pix_ack   <= 1'b1;
                img_wr_en <= 1'b1;
                // no further requests after the last pixel
                if (img_wr_addr == LAST_ADDR) begin
                    full <= 1'b1;
                end
            end else if (pix_ack && !pix_req) begin
                pix_ack <= 1'b0;
                // image complete once the final handshake closes
                if (full) begin
                    load_done <= 1'b1;
                end
            end
            // address moves on after its write strobe
            if (img_wr_en && !full) begin
                img_wr_addr <= img_wr_addr + cnn_pkg::img_addr_t'(1);
            end
        end
    end

endmodule

// ==== layer_sequencer.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Layer phase sequencer
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// runs load, conv, pool and fc in turn for each start handshake
module layer_sequencer (
    input  logic            clk,
    input  logic            reset,
    input  logic            start_req,
    input  logic            load_done,
    input  logic            conv_last,
    input  logic            pool_last,
    input  logic            fc_last,
    output logic            start_ack,
    output logic            load_en,
    output logic            conv_en,
    output logic            pool_en,
    output logic            fc_en,
    output cnn_pkg::phase_t phase
);

    cnn_pkg::phase_t phase_next;
    logic            ack_next;

    always_comb begin
        phase_next = phase;
        ack_next   = start_ack;
        case (phase)
            cnn_pkg::phase_idle: begin
                // start only taken from idle
                if (start_req) begin
                    phase_next = cnn_pkg::phase_load;
                end
            end
            cnn_pkg::phase_load: begin
                if (load_done) begin
                    phase_next = cnn_pkg::phase_conv;
                end
            end
            cnn_pkg::phase_conv: begin
                if (conv_last) begin
                    phase_next = cnn_pkg::phase_pool;
                end
            end
            cnn_pkg::phase_pool: begin
                if (pool_last) begin
                    phase_next = cnn_pkg::phase_fc;
                end
            end
            cnn_pkg::phase_fc: begin
                // ack goes up together with the move to finish
                if (fc_last) begin
                    phase_next = cnn_pkg::phase_finish;
                    ack_next   = 1'b1;
                end
            end
            cnn_pkg::phase_finish: begin
                // hold ack until the host lets go of the request
                if (!start_req) begin
                    phase_next = cnn_pkg::phase_idle;
                    ack_next   = 1'b0;
                end
            end
            default: begin
                phase_next = cnn_pkg::phase_idle;
                ack_next   = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase     <= cnn_pkg::phase_idle;
            start_ack <= 1'b0;
        end else begin
            phase     <= phase_next;
            start_ack <= ack_next;
        end
    end

    // one layer enable per active phase
    assign load_en = (phase == cnn_pkg::phase_load);
    assign conv_en = (phase == cnn_pkg::phase_conv);
    assign pool_en = (phase == cnn_pkg::phase_pool);
    assign fc_en   = (phase == cnn_pkg::phase_fc);

endmodule

// ==== cnn_addr_top.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CNN address generation core
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "cnn_settings.svh"

module cnn_addr_top (
    input  logic                clk,
    input  logic                reset,
    input  logic                start_req,
    input  logic                pix_req,
    output logic                start_ack,
    output logic                pix_ack,
    output logic                img_wr_en,
    output logic                conv_rd_en,
    output logic                conv_wr_en,
    output logic                pool_rd_en,
    output logic                pool_wr_en,
    output logic                fc_rd_en,
    output cnn_pkg::phase_t     phase,
    output cnn_pkg::img_addr_t  img_wr_addr,
    output cnn_pkg::k_addr_t    k_addr0,
    output cnn_pkg::k_addr_t    k_addr1,
    output cnn_pkg::conv_addr_t conv_wr_addr0,
    output cnn_pkg::conv_addr_t conv_wr_addr1,
    output cnn_pkg::conv_addr_t pool_a0,
    output cnn_pkg::conv_addr_t pool_a1,
    output cnn_pkg::conv_addr_t pool_a2,
    output cnn_pkg::conv_addr_t pool_a3,
    output cnn_pkg::conv_addr_t pool_b0,
    output cnn_pkg::conv_addr_t pool_b1,
    output cnn_pkg::conv_addr_t pool_b2,
    output cnn_pkg::conv_addr_t pool_b3,
    output cnn_pkg::pool_addr_t pool_wr_addr0,
    output cnn_pkg::pool_addr_t pool_wr_addr1,
    output cnn_pkg::fc_addr_t   fc_addr0,
    output cnn_pkg::fc_addr_t   fc_addr1
);

    localparam int K_TAPS = `CNN_K_SIDE * `CNN_K_SIDE;

    logic load_en;
    logic load_done;
    logic conv_en;
    logic pool_en;
    logic fc_en;
    logic k_last;
    logic cw_last;
    logic conv_last;
    logic pool_last;
    logic fc_last;

    layer_sequencer u_seq (
        .clk       (clk),
        .reset     (reset),
        .start_req (start_req),
        .load_done (load_done),
        .conv_last (conv_last),
        .pool_last (pool_last),
        .fc_last   (fc_last),
        .start_ack (start_ack),
        .load_en   (load_en),
        .conv_en   (conv_en),
        .pool_en   (pool_en),
        .fc_en     (fc_en),
        .phase     (phase)
    );

    img_load_ctrl u_load (
        .clk         (clk),
        .reset       (reset),
        .load_en     (load_en),
        .pix_req     (pix_req),
        .pix_ack     (pix_ack),
        .img_wr_en   (img_wr_en),
        .load_done   (load_done),
        .img_wr_addr (img_wr_addr)
    );

    // kernel tap, one per cycle, filter 1 right after filter 0
    linear_addr_gen #(
        .WIDTH       ($bits(cnn_pkg::k_addr_t)),
        .LANE_OFFSET (K_TAPS),
        .LAST        (K_TAPS - 1)
    ) u_k_gen (
        .clk   (clk),
        .reset (reset),
        .run   (conv_en),
        .step  (conv_en),
        .addr0 (k_addr0),
        .addr1 (k_addr1),
        .last  (k_last)
    );

    // conv output pixel, moves on when the tap wraps
    linear_addr_gen #(
        .WIDTH       ($bits(cnn_pkg::conv_addr_t)),
        .LANE_OFFSET (`CNN_CONV_PLANE),
        .LAST        (`CNN_CONV_PLANE - 1)
    ) u_conv_wr_gen (
        .clk   (clk),
        .reset (reset),
        .run   (conv_en),
        .step  (k_last),
        .addr0 (conv_wr_addr0),
        .addr1 (conv_wr_addr1),
        .last  (cw_last)
    );

    pool_window_addr_gen u_pool_rd_gen (
        .clk   (clk),
        .reset (reset),
        .run   (pool_en),
        .a0    (pool_a0),
        .a1    (pool_a1),
        .a2    (pool_a2),
        .a3    (pool_a3),
        .b0    (pool_b0),
        .b1    (pool_b1),
        .b2    (pool_b2),
        .b3    (pool_b3),
        .last  (pool_last)
    );

    // one pooled word per window
    linear_addr_gen #(
        .WIDTH       ($bits(cnn_pkg::pool_addr_t)),
        .LANE_OFFSET (`CNN_POOL_PLANE),
        .LAST        (`CNN_POOL_PLANE - 1)
    ) u_pool_wr_gen (
        .clk   (clk),
        .reset (reset),
        .run   (pool_en),
        .step  (pool_en),
        .addr0 (pool_wr_addr0),
        .addr1 (pool_wr_addr1),
        .last  ()
    );

    linear_addr_gen #(
        .WIDTH       ($bits(cnn_pkg::fc_addr_t)),
        .LANE_OFFSET (`CNN_FC_PLANE),
        .LAST        (`CNN_FC_PLANE - 1)
    ) u_fc_gen (
        .clk   (clk),
        .reset (reset),
        .run   (fc_en),
        .step  (fc_en),
        .addr0 (fc_addr0),
        .addr1 (fc_addr1),
        .last  (fc_last)
    );

    // last tap of the last output pixel ends the conv layer
    assign conv_last = k_last & cw_last;

    assign conv_rd_en = conv_en;
    assign conv_wr_en = k_last;
    assign pool_rd_en = pool_en;
    assign pool_wr_en = pool_en;
    assign fc_rd_en   = fc_en;

endmodule

// ==== tb_cnn_addr.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CNN address core testbench
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "cnn_settings.svh"

module tb_cnn_addr;

    localparam int IMG_WORDS  = `CNN_IMG_SIDE * `CNN_IMG_SIDE;
    localparam int TAPS       = `CNN_K_SIDE * `CNN_K_SIDE;
    localparam int CONV_WORDS = `CNN_CONV_SIDE * `CNN_CONV_SIDE;
    localparam int POOL_WORDS = `CNN_POOL_SIDE * `CNN_POOL_SIDE;
    // two runs, each allowed twice its worst case length
    localparam int CYCLE_LIMIT =
        2 * (IMG_WORDS * 12 + CONV_WORDS * TAPS + POOL_WORDS + `CNN_FC_PLANE + 50) * 2;

    logic clk, reset, start_req, pix_req;
    logic start_ack, pix_ack, img_wr_en, conv_rd_en, conv_wr_en;
    logic pool_rd_en, pool_wr_en, fc_rd_en;
    cnn_pkg::phase_t     phase;
    cnn_pkg::img_addr_t  img_wr_addr;
    cnn_pkg::k_addr_t    k_addr0, k_addr1;
    cnn_pkg::conv_addr_t conv_wr_addr0, conv_wr_addr1;
    cnn_pkg::conv_addr_t pool_a0, pool_a1, pool_a2, pool_a3;
    cnn_pkg::conv_addr_t pool_b0, pool_b1, pool_b2, pool_b3;
    cnn_pkg::pool_addr_t pool_wr_addr0, pool_wr_addr1;
    cnn_pkg::fc_addr_t   fc_addr0, fc_addr1;

    int          errors, tests_pass, tests_fail, cycles, wr_count, err0;
    int unsigned sig, seed, dummy;
    int unsigned run_sig [2];
    logic        prev_ack;

    cnn_addr_top dut (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic check_img(input string name, input cnn_pkg::img_addr_t exp,
                             input cnn_pkg::img_addr_t act);
        if (act !== exp) begin
            errors++;
            $display("Fail t=%0t %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_k(input string name, input cnn_pkg::k_addr_t exp,
                           input cnn_pkg::k_addr_t act);
        if (act !== exp) begin
            errors++;
            $display("Fail t=%0t %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_conv(input string name, input cnn_pkg::conv_addr_t exp,
                              input cnn_pkg::conv_addr_t act);
        if (act !== exp) begin
            errors++;
            $display("Fail t=%0t %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_pool(input string name, input cnn_pkg::pool_addr_t exp,
                              input cnn_pkg::pool_addr_t act);
        if (act !== exp) begin
            errors++;
            $display("Fail t=%0t %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_fc(input string name, input cnn_pkg::fc_addr_t exp,
                            input cnn_pkg::fc_addr_t act);
        if (act !== exp) begin
            errors++;
            $display("Fail t=%0t %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_phase(input cnn_pkg::phase_t exp, input cnn_pkg::phase_t act);
        if (act !== exp) begin
            errors++;
            $display("Fail t=%0t phase expected %0d got %0d", $time, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("Fail t=%0t %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    task automatic close_test(input string name, input int err_before);
        if (errors == err_before) begin
            tests_pass++;
            $display("%s: pass", name);
        end else begin
            tests_fail++;
            $display("%s: fail with %0d errors", name, errors - err_before);
        end
    endtask

    // outputs are read just after the inputs were driven
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // one cycle of the pixel source, with the four-phase rules
    task automatic load_cycle();
        logic req_before;
        req_before = pix_req;
        next_cycle();
        if (img_wr_en) begin
            if (prev_ack || !pix_ack) begin
                errors++;
                $display("write strobe at t=%0t came without a rising pix_ack", $time);
            end
            check_img("img_wr_addr", cnn_pkg::img_addr_t'(wr_count), img_wr_addr);
            sig = sig * 33 + img_wr_addr;
            wr_count++;
        end else if (pix_ack && !prev_ack) begin
            errors++;
            $display("pix_ack rose at t=%0t without a write strobe", $time);
        end
        if (prev_ack && !pix_ack && req_before) begin
            errors++;
            $display("pix_ack fell at t=%0t while pix_req was still high", $time);
        end
        if (prev_ack && pix_ack && !req_before) begin
            errors++;
            $display("pix_ack stayed high at t=%0t after pix_req was low", $time);
        end
        prev_ack = pix_ack;
    endtask

    task automatic run_once(input int run);
        int d, n, tap, base, writes;
        sig      = 0;
        wr_count = 0;
        prev_ack = 1'b0;
        err0     = errors;
        start_req = 1'b1;
        for (int i = 0; i < IMG_WORDS; i++) begin
            d = $urandom % 6;
            repeat (d) load_cycle();
            pix_req = 1'b1;
            while (!pix_ack) load_cycle();
            d = $urandom % 4;
            repeat (d) load_cycle();
            pix_req = 1'b0;
            while (pix_ack) load_cycle();
        end
        if (wr_count != IMG_WORDS) begin
            errors++;
            $display("image load gave %0d writes instead of %0d", wr_count, IMG_WORDS);
        end
        while (phase != cnn_pkg::phase_conv) next_cycle();
        close_test($sformatf("run %0d image load", run), err0);

        err0   = errors;
        writes = 0;
        for (n = 0; n < CONV_WORDS * TAPS; n++) begin
            tap = n % TAPS;
            check_phase(cnn_pkg::phase_conv, phase);
            check_flag("conv_rd_en", 1'b1, conv_rd_en);
            check_k("k_addr0", cnn_pkg::k_addr_t'(tap), k_addr0);
            check_k("k_addr1", cnn_pkg::k_addr_t'(tap + TAPS), k_addr1);
            check_flag("conv_wr_en", tap == TAPS - 1, conv_wr_en);
            if (conv_wr_en) begin
                check_conv("conv_wr_addr0", cnn_pkg::conv_addr_t'(n / TAPS), conv_wr_addr0);
                check_conv("conv_wr_addr1",
                           cnn_pkg::conv_addr_t'(n / TAPS + `CNN_CONV_PLANE), conv_wr_addr1);
                sig = sig * 33 + conv_wr_addr0;
                writes++;
            end
            next_cycle();
        end
        if (writes != CONV_WORDS) begin
            errors++;
            $display("conv layer gave %0d writes instead of %0d", writes, CONV_WORDS);
        end
        close_test($sformatf("run %0d conv", run), err0);

        err0 = errors;
        for (n = 0; n < POOL_WORDS; n++) begin
            // window top-left skips every odd conv row
            base = 2 * (n % `CNN_POOL_SIDE) + 2 * `CNN_CONV_SIDE * (n / `CNN_POOL_SIDE);
            check_phase(cnn_pkg::phase_pool, phase);
            check_flag("pool_rd_en", 1'b1, pool_rd_en);
            check_flag("pool_wr_en", 1'b1, pool_wr_en);
            check_conv("pool_a0", cnn_pkg::conv_addr_t'(base), pool_a0);
            check_conv("pool_a1", cnn_pkg::conv_addr_t'(base + 1), pool_a1);
            check_conv("pool_a2", cnn_pkg::conv_addr_t'(base + `CNN_CONV_SIDE), pool_a2);
            check_conv("pool_a3", cnn_pkg::conv_addr_t'(base + `CNN_CONV_SIDE + 1), pool_a3);
            base = base + `CNN_CONV_PLANE;
            check_conv("pool_b0", cnn_pkg::conv_addr_t'(base), pool_b0);
            check_conv("pool_b1", cnn_pkg::conv_addr_t'(base + 1), pool_b1);
            check_conv("pool_b2", cnn_pkg::conv_addr_t'(base + `CNN_CONV_SIDE), pool_b2);
            check_conv("pool_b3", cnn_pkg::conv_addr_t'(base + `CNN_CONV_SIDE + 1), pool_b3);
            check_pool("pool_wr_addr0", cnn_pkg::pool_addr_t'(n), pool_wr_addr0);
            check_pool("pool_wr_addr1", cnn_pkg::pool_addr_t'(n + `CNN_POOL_PLANE),
                       pool_wr_addr1);
            sig = sig * 33 + pool_a0 + pool_wr_addr0;
            next_cycle();
        end
        close_test($sformatf("run %0d pool", run), err0);

        err0 = errors;
        for (n = 0; n < `CNN_FC_PLANE; n++) begin
            check_phase(cnn_pkg::phase_fc, phase);
            check_flag("fc_rd_en", 1'b1, fc_rd_en);
            check_fc("fc_addr0", cnn_pkg::fc_addr_t'(n), fc_addr0);
            check_fc("fc_addr1", cnn_pkg::fc_addr_t'(n + `CNN_FC_PLANE), fc_addr1);
            sig = sig * 33 + fc_addr0;
            next_cycle();
        end
        // host holds the request a while after the ack
        check_phase(cnn_pkg::phase_finish, phase);
        check_flag("start_ack", 1'b1, start_ack);
        d = $urandom % 4;
        repeat (d) begin
            next_cycle();
            check_flag("start_ack", 1'b1, start_ack);
        end
        start_req = 1'b0;
        next_cycle();
        check_phase(cnn_pkg::phase_idle, phase);
        check_flag("start_ack", 1'b0, start_ack);
        close_test($sformatf("run %0d fc and finish", run), err0);
        run_sig[run - 1] = sig;
    endtask

    initial begin
        seed = 32'h158bcca9;
        dummy = $urandom(seed);
        clk = 1'b0;
        reset = 1'b1;
        start_req = 1'b0;
        pix_req = 1'b0;
        errors = 0;
        tests_pass = 0;
        tests_fail = 0;
        cycles = 0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        err0 = errors;
        check_phase(cnn_pkg::phase_idle, phase);
        check_flag("start_ack", 1'b0, start_ack);
        check_flag("pix_ack", 1'b0, pix_ack);
        check_flag("img_wr_en", 1'b0, img_wr_en);
        check_flag("conv_rd_en", 1'b0, conv_rd_en);
        check_flag("conv_wr_en", 1'b0, conv_wr_en);
        check_flag("pool_rd_en", 1'b0, pool_rd_en);
        check_flag("pool_wr_en", 1'b0, pool_wr_en);
        check_flag("fc_rd_en", 1'b0, fc_rd_en);
        close_test("reset state", err0);

        run_once(1);
        run_once(2);

        err0 = errors;
        if (run_sig[0] != run_sig[1]) begin
            errors++;
            $display("second run produced a different address sequence than the first");
        end
        close_test("second run repeats first", err0);

        $display("tests passed %0d, failed %0d", tests_pass, tests_fail);
        if (errors == 0 && tests_fail == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== list.f ====
cnn_pkg.sv
linear_addr_gen.sv
pool_window_addr_gen.sv
img_load_ctrl.sv
layer_sequencer.sv
cnn_addr_top.sv
tb_cnn_addr.sv
+incdir+.
